/* src/spi_pkg.sv */
// shared SPI byte, request and response types and register addresses, imported by every SPI block
package spi_pkg;

    // one byte as it travels on the wire
    typedef logic [7:0] spi_byte_t;

    // what the host sent, from the peripheral toward the selector and registers
    typedef struct packed {
        spi_byte_t address;
        // one cycle per transaction, after the first byte
        logic      address_valid;
        spi_byte_t copi;
        // one cycle per completed data byte
        logic      copi_valid;
    } spi_request_t;

    // what a register offers back toward the peripheral
    typedef struct packed {
        // next byte to shift out
        spi_byte_t cipo;
        // low means the peripheral sends 0x00 instead
        logic      cipo_valid;
    } spi_response_t;

    // register map
    localparam spi_byte_t chip_id_address        = 8'hdb;
    localparam spi_byte_t version_string_address = 8'hb5;

endpackage

/* src/spi_peripheral.sv */
// SPI mode 0 byte peripheral that raises address and data strobes and shifts response bytes out
`timescale 1ns/10ps

module spi_peripheral
    import spi_pkg::*;
(
    input  logic          clock,
    input  logic          rst_n,
    input  logic          spi_select,
    input  logic          spi_sck,
    input  logic          spi_copi,
    input  spi_response_t response,
    output logic          spi_cipo,
    output spi_request_t  request,
    output logic          active
);

    // pin order in the synchronizer is {copi, sck, select}
    logic [2:0] pin_meta;
    logic [2:0] pin_sync;
    logic       select_sync;
    logic       sck_sync;
    logic       copi_sync;
    logic       sck_last;
    logic       sck_rise;
    logic       sck_fall;

    // byte assembly
    logic [2:0] bit_count;
    logic [6:0] copi_shift;
    logic       first_byte;
    spi_byte_t  copi_byte;
    spi_byte_t  address_q;
    logic       address_valid_q;
    spi_byte_t  copi_q;
    logic       copi_valid_q;

    // response path
    spi_byte_t  cipo_shift;

    // double-flop synchronizer, select idles high
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pin_meta <= 3'b001;
            pin_sync <= 3'b001;
        end else begin
            pin_meta <= {spi_copi, spi_sck, spi_select};
            pin_sync <= pin_meta;
        end
    end

    assign select_sync = pin_sync[0];
    assign sck_sync    = pin_sync[1];
    assign copi_sync   = pin_sync[2];

    // edge detect on the synchronized clock
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sck_last <= 1'b0;
        end else begin
            sck_last <= sck_sync;
        end
    end

    assign sck_rise = sck_sync & ~sck_last;
    assign sck_fall = ~sck_sync & sck_last;
    assign active   = ~select_sync;

    // MSB first, the current bit completes the byte
    assign copi_byte = {copi_shift, copi_sync};

    // bit counter and strobes
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bit_count       <= '0;
            first_byte      <= 1'b1;
            address_valid_q <= 1'b0;
            copi_valid_q    <= 1'b0;
        end else begin
            address_valid_q <= 1'b0;
            copi_valid_q    <= 1'b0;
            if (select_sync) begin
                // partial byte is dropped here
                bit_count  <= '0;
                first_byte <= 1'b1;
            end else if (sck_rise) begin
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    first_byte <= 1'b0;
                    if (first_byte) begin
                        address_valid_q <= 1'b1;
                    end else begin
                        copi_valid_q <= 1'b1;
                    end
                end
            end
        end
    end

    // data shift and byte capture
    always_ff @(posedge clock) begin
        if (sck_rise && !select_sync) begin
            copi_shift <= copi_byte[6:0];
            if (bit_count == 3'd7) begin
                if (first_byte) begin
                    address_q <= copi_byte;
                end else begin
                    copi_q <= copi_byte;
                end
            end
        end
    end

    assign request = '{
        address:       address_q,
        address_valid: address_valid_q,
        copi:          copi_q,
        copi_valid:    copi_valid_q
    };

    // load on the falling edge that opens a data byte, shift on the others
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cipo_shift <= '0;
        end else if (select_sync) begin
            cipo_shift <= '0;
        end else if (sck_fall) begin
            if (bit_count == 3'd0 && !first_byte) begin
                cipo_shift <= response.cipo_valid ? response.cipo : 8'h00;
            end else begin
                cipo_shift <= {cipo_shift[6:0], 1'b0};
            end
        end
    end

    assign spi_cipo = cipo_shift[7];

    // address and data strobes are exclusive
    assert property (@(posedge clock) disable iff (!rst_n)
        !(request.address_valid && request.copi_valid));

endmodule

/* src/spi_subperipheral_selector.sv */
// address decoder that enables one SPI register per transaction and muxes its response byte
`timescale 1ns/10ps

module spi_subperipheral_selector
    import spi_pkg::*;
#(
    parameter spi_byte_t chip_id = 8'h81
) (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          active,
    input  spi_request_t  request,
    input  spi_response_t version_response,
    output logic          version_enable,
    output spi_response_t response
);

    spi_byte_t  address_q;
    logic       selected;
    // bit 0 chip id, bit 1 version string
    logic [1:0] enables;

    // open on the address strobe, close when select rises
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            selected <= 1'b0;
        end else if (!active) begin
            selected <= 1'b0;
        end else if (request.address_valid) begin
            selected <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (request.address_valid) begin
            address_q <= request.address;
        end
    end

    assign enables[0] = selected && (address_q == chip_id_address);
    assign enables[1] = selected && (address_q == version_string_address);

    assign version_enable = enables[1];

    // chip id is answered here, unknown addresses read as zero
    always_comb begin
        response = '{cipo: 8'h00, cipo_valid: 1'b0};
        if (enables[0]) begin
            response = '{cipo: chip_id, cipo_valid: 1'b1};
        end else if (enables[1]) begin
            response = version_response;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(enables));

endmodule

/* src/spi_register_version_string.sv */
// SPI register that streams a version string one character per data byte while enabled
`timescale 1ns/10ps

module spi_register_version_string
    import spi_pkg::*;
#(
    parameter int                          version_length = 8,
    parameter logic [8*version_length-1:0] version_string = "v24.0101"
) (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          enable,
    input  logic          copi_valid,
    output spi_response_t response
);

    localparam int index_width = $clog2(version_length + 1);
    // one past the last character
    localparam logic [index_width-1:0] end_index = index_width'(version_length);

    logic [index_width-1:0] index;
    spi_byte_t              character;

    // restart from the first character on each new enable
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            index <= '0;
        end else if (!enable) begin
            index <= '0;
        end else if (copi_valid && index != end_index) begin
            index <= index + 1'b1;
        end
    end

    // first character sits in the top byte of the string
    always_comb begin
        character = 8'h00;
        if (index < end_index) begin
            character = version_string[8*(version_length-1-index) +: 8];
        end
    end

    assign response = '{cipo: character, cipo_valid: enable};

    assert property (@(posedge clock) disable iff (!rst_n)
        index <= end_index);

endmodule

/* src/spi_top.sv */
// top level of the SPI register path, connecting peripheral, selector and version string register
`timescale 1ns/10ps

module spi_top
    import spi_pkg::*;
#(
    parameter spi_byte_t                   chip_id        = 8'h81,
    parameter int                          version_length = 8,
    parameter logic [8*version_length-1:0] version_string = "v24.0101"
) (
    input  logic clock,
    input  logic rst_n,
    input  logic spi_select,
    input  logic spi_sck,
    input  logic spi_copi,
    output logic spi_cipo
);

    // host side
    spi_request_t  request;
    logic          active;

    // register side
    spi_response_t response;
    spi_response_t version_response;
    logic          version_enable;

    spi_peripheral spi_peripheral_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .spi_select (spi_select),
        .spi_sck    (spi_sck),
        .spi_copi   (spi_copi),
        .response   (response),
        .spi_cipo   (spi_cipo),
        .request    (request),
        .active     (active)
    );

    spi_subperipheral_selector #(
        .chip_id (chip_id)
    ) spi_subperipheral_selector_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .active           (active),
        .request          (request),
        .version_response (version_response),
        .version_enable   (version_enable),
        .response         (response)
    );

    // data strobe paces the string
    spi_register_version_string #(
        .version_length (version_length),
        .version_string (version_string)
    ) spi_register_version_string_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .enable     (version_enable),
        .copi_valid (request.copi_valid),
        .response   (version_response)
    );

endmodule

/* tests/spi_host_tasks.svh */
// SPI mode 0 host tasks, included inside the testbench module to drive the pins of the DUT
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// every wait ends on a falling clock edge, where the pins change
task automatic wait_cycles(input int count);
    repeat (count) @(negedge clock);
endtask

// one bit per SCK period, MSB first, reply sampled just before SCK rises
task automatic transfer_byte(input spi_byte_t tx, output spi_byte_t rx);
    rx = 8'h00;
    for (int i = 7; i >= 0; i--) begin
        spi_copi = tx[i];
        wait_cycles(half_bit_clocks);
        rx[i] = spi_cipo;
        spi_sck = 1'b1;
        wait_cycles(half_bit_clocks);
        spi_sck = 1'b0;
    end
endtask

// leading bits of a byte only, for transfers cut short by select
task automatic send_bits(input spi_byte_t tx, input int count);
    for (int i = 7; i > 7 - count; i--) begin
        spi_copi = tx[i];
        wait_cycles(half_bit_clocks);
        spi_sck = 1'b1;
        wait_cycles(half_bit_clocks);
        spi_sck = 1'b0;
    end
endtask

task automatic begin_transaction();
    spi_select = 1'b0;
    wait_cycles(half_bit_clocks);
endtask

// idle gap long enough for the enables to drop
task automatic end_transaction();
    wait_cycles(half_bit_clocks);
    spi_select = 1'b1;
    spi_copi   = 1'b0;
    wait_cycles(2 * half_bit_clocks);
endtask

`endif

/* tests/tb_spi_top.sv */
// directed testbench for the SPI register path, run from tb.f with spi_top as the DUT
`timescale 1ns/10ps

module tb_spi_top
    import spi_pkg::*;
;

    // clocks per half SCK period
    localparam int half_bit_clocks = 16;

    // expected register contents
    localparam spi_byte_t expected_chip_id = 8'h81;
    localparam int expected_version_length = 8;
    localparam string expected_version = "v24.0101";

    // chip id 5, version 11, restart 5 + 9, unknown 15, repeat 5
    localparam int total_bytes = 50;
    localparam int timeout_cycles = total_bytes * 16 * 32 + 4000;

    logic clock;
    logic rst_n;
    logic spi_select;
    logic spi_sck;
    logic spi_copi;
    logic spi_cipo;

    logic [15:0] lfsr_state;
    int          cycle_count;

    spi_top spi_top_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .spi_select (spi_select),
        .spi_sck    (spi_sck),
        .spi_copi   (spi_copi),
        .spi_cipo   (spi_cipo)
    );

    `include "spi_host_tasks.svh"

    always #50 clock = ~clock;

    // prints the reason and the verdict, then stops
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input spi_byte_t expected,
                              input spi_byte_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t: %s expected 0x%02h got 0x%02h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t: %s expected %b got %b",
                                $time, name, expected, actual));
        end
    endtask

    // galois form, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    task automatic random_byte(output spi_byte_t value);
        value = 8'h00;
        for (int b = 0; b < 8; b++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // characters in reading order
    function automatic spi_byte_t version_char(input int position);
        string text;
        text = expected_version;
        return text.getc(position);
    endfunction

    task automatic idle_cipo_low();
        for (int k = 0; k < 8; k++) begin
            wait_cycles(1);
            check_level("spi_cipo after reset", 1'b0, spi_cipo);
        end
    endtask

    task automatic chip_id_read();
        spi_byte_t tx;
        spi_byte_t rx;
        begin_transaction();
        transfer_byte(chip_id_address, rx);
        for (int k = 0; k < 4; k++) begin
            random_byte(tx);
            transfer_byte(tx, rx);
            check_byte($sformatf("chip id byte %0d", k), expected_chip_id, rx);
        end
        end_transaction();
    endtask

    // data bytes of an open version string transaction
    task automatic read_version(input int count);
        spi_byte_t tx;
        spi_byte_t rx;
        for (int k = 0; k < count; k++) begin
            random_byte(tx);
            transfer_byte(tx, rx);
            check_byte($sformatf("version char %0d", k), version_char(k), rx);
        end
    endtask

    task automatic version_string_read();
        spi_byte_t tx;
        spi_byte_t rx;
        begin_transaction();
        transfer_byte(version_string_address, rx);
        read_version(expected_version_length);
        // past the end the register reads zero
        for (int k = 0; k < 2; k++) begin
            random_byte(tx);
            transfer_byte(tx, rx);
            check_byte($sformatf("version tail byte %0d", k), 8'h00, rx);
        end
        end_transaction();
    endtask

    task automatic version_read_restart();
        spi_byte_t tx;
        spi_byte_t rx;
        begin_transaction();
        transfer_byte(version_string_address, rx);
        read_version(3);
        // select rises in the middle of the fourth byte
        random_byte(tx);
        send_bits(tx, 3);
        end_transaction();
        begin_transaction();
        transfer_byte(version_string_address, rx);
        read_version(expected_version_length);
        end_transaction();
    endtask

    task automatic unknown_address_reads();
        spi_byte_t address;
        spi_byte_t tx;
        spi_byte_t rx;
        for (int n = 0; n < 5; n++) begin
            random_byte(address);
            while (address == chip_id_address || address == version_string_address) begin
                random_byte(address);
            end
            begin_transaction();
            transfer_byte(address, rx);
            for (int k = 0; k < 2; k++) begin
                random_byte(tx);
                transfer_byte(tx, rx);
                check_byte($sformatf("address 0x%02h byte %0d", address, k), 8'h00, rx);
            end
            end_transaction();
        end
    endtask

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        abort_run($sformatf("timeout after %0d clock cycles with tests still running",
                            cycle_count));
    end

    initial begin
        clock      = 1'b0;
        rst_n      = 1'b0;
        spi_select = 1'b1;
        spi_sck    = 1'b0;
        spi_copi   = 1'b0;
        lfsr_state = 16'd1695;
        wait_cycles(2);
        rst_n = 1'b1;

        idle_cipo_low();
        chip_id_read();
        version_string_read();
        version_read_restart();
        unknown_address_reads();
        // same read again, the LFSR has moved on to new data bytes
        chip_id_read();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+tests
src/spi_pkg.sv
src/spi_peripheral.sv
src/spi_subperipheral_selector.sv
src/spi_register_version_string.sv
src/spi_top.sv
tests/tb_spi_top.sv
